//--- decoder.f
verilog/dec_cfg_pkg.sv
verilog/dec_sym_pkg.sv
verilog/decoder_ctrl.sv
verilog/biphase_to_nrz.sv
verilog/mark_space_decode.sv
verilog/iq_demux.sv
verilog/derandomizer.sv
verilog/decoder.sv
tests/decoder_checker.sv
tests/decoder_tb.sv

//--- Makefile
# Verilator simulation of the decoder testbench

TOP = decoder_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f decoder.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- tests/decoder_tb.sv
//----------------------------------------
// decoder testbench with bus tasks, random symbols,
// reference model and checks
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decoder_tb;

  import dec_cfg_pkg::*;
  import dec_sym_pkg::*;

  localparam int RUN_SYMS    = 150;
  localparam int COUNT_SYMS  = 1000;
  localparam int DERAND_SYMS = 200;
  // count run, 12 short mode runs, 5 polynomials
  localparam int TOTAL_SYMS  = COUNT_SYMS + 12 * RUN_SYMS + 5 * DERAND_SYMS;
  localparam int MAX_CYCLES  = TOTAL_SYMS * 8 + 4000;

  logic      clk;
  logic      rs;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;
  logic      symb_en;
  logic      symb2x_en;
  sym_t      sym;
  dec_bits_t bits;
  logic      symb_clk;

  // symbol history
  // hist_d holds data before scrambling
  logic      hist_i [0:8191];
  logic      hist_q [0:8191];
  logic      hist_d [0:8191];
  int        sym_idx;
  logic      run_en;
  logic      go;
  logic [2:0] ph;
  // last half-symbol enable was a symbol start
  logic      last_e;
  logic      bip_half;
  logic      bip_i;
  logic      bip_q;
  int        tap_a;
  int        tap_b;
  dec_cfg_t  cur_cfg;
  int        skip;
  int        errors;
  int        checks;
  int        test_err;
  int        test_chk;
  int        cycles;
  int        asrt;
  logic [15:0] rd;
  logic [15:0] c;

  decoder dut_i (
    .clk         (clk),
    .rs          (rs),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .symb_en_i   (symb_en),
    .symb2x_en_i (symb2x_en),
    .sym_i       (sym),
    .bits_o      (bits),
    .symb_clk_o  (symb_clk)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //----------------------------------------
  // reference model
  //----------------------------------------
  function automatic logic nrz_decode(input logic cur, input logic prev);
    case (cur_cfg.nrz_mode)
      NRZ_M:   return cur ^ prev;
      NRZ_S:   return !(cur ^ prev);
      default: return cur;
    endcase
  endfunction

  // bits expected at the strobe carrying symbol j
  function automatic logic [1:0] expected_bits(input int j);
    logic di;
    logic dq;
    logic dp;
    logic b;
    logic ei;
    logic eq;
    if (cur_cfg.biphase)
    begin
      // first half of the pair holds the bit
      ei = hist_i[j - 1];
      eq = hist_q[j - 1];
    end
    else
    begin
      di = nrz_decode(hist_i[j], hist_i[j - 1]);
      dq = nrz_decode(hist_q[j], hist_q[j - 1]);
      dp = nrz_decode(hist_i[j - 1], hist_i[j - 2]);
      case (cur_cfg.demux)
        DEMUX_QPSK:
        begin
          b  = (last_e ^ cur_cfg.swap) ? di : dq;
          ei = b;
          eq = !b;
        end
        DEMUX_FQPSK:
        begin
          b  = last_e ? (dp ^ dq ^ cur_cfg.swap) : (di ^ dq ^ !cur_cfg.swap);
          ei = b;
          eq = !b;
        end
        default:
        begin
          if (cur_cfg.derand != DERAND_OFF)
          begin
            ei = hist_d[j];
            eq = hist_d[j];
          end
          else
          begin
            ei = cur_cfg.swap ? dq : di;
            eq = cur_cfg.swap ? di : dq;
          end
        end
      endcase
    end
    return {ei ^ cur_cfg.data_inv, eq ^ cur_cfg.data_inv};
  endfunction

  //----------------------------------------
  // symbol generation
  //----------------------------------------
  task automatic next_symbol();
    logic si;
    logic sq;
    logic d;
    if (cur_cfg.biphase)
    begin
      // high/low pair for 1, low/high for 0
      if (!bip_half)
      begin
        bip_i = 1'($urandom);
        bip_q = 1'($urandom);
      end
      si       = bip_half ? !bip_i : bip_i;
      sq       = bip_half ? !bip_q : bip_q;
      bip_half = !bip_half;
    end
    else
    begin
      si = 1'($urandom);
      sq = 1'($urandom);
    end
    d = si;
    // self-synchronizing scrambler over sent bits
    if (tap_a != 0 && sym_idx >= 23)
      si = d ^ hist_i[sym_idx - tap_a] ^ hist_i[sym_idx - tap_b];
    hist_i[sym_idx] = si;
    hist_q[sym_idx] = sq;
    hist_d[sym_idx] = d;
    sym.i     = si;
    sym.q     = sq;
    sym.valid = 1'b1;
    sym_idx++;
  endtask

  // symb2x every 4 clocks, symb every 8
  always @(posedge clk)
  begin
    go = run_en;
    #1;
    if (go)
    begin
      symb2x_en = (ph[1:0] == 2'd0);
      symb_en   = (ph == 3'd0);
      if (symb2x_en)
        last_e = symb_en;
      if (symb_en)
        next_symbol();
      ph = ph + 3'd1;
    end
    else
    begin
      symb_en   = 1'b0;
      symb2x_en = 1'b0;
      ph        = 3'd0;
    end
  end

  //----------------------------------------
  // output monitor
  //----------------------------------------
  task automatic check_bits();
    int         j;
    logic [1:0] exp;
    // symbol clock high after a symbol start, low after mid-symbol
    if (symb_clk != last_e)
    begin
      errors++;
      $display("Mismatch at %0t ns: symbol clock %b, expected %b", $time, symb_clk, last_e);
    end
    if (skip > 0)
      skip--;
    else
    begin
      // strobe lags the sampled symbol by two symbol enables
      j   = sym_idx - 3;
      exp = expected_bits(j);
      checks++;
      if ({bits.bit_i, bits.bit_q} != exp)
      begin
        errors++;
        $display("Mismatch at %0t ns: symbol %0d got i=%b q=%b, expected i=%b q=%b",
                 $time, j, bits.bit_i, bits.bit_q, exp[1], exp[0]);
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (!rs && bits.strobe)
      check_bits();
  end

  //----------------------------------------
  // bus and mode tasks
  //----------------------------------------
  task automatic bus_cycle(input logic we, input addr_t addr, input logic [15:0] wdata,
                           output logic [15:0] rdata);
    int wait_cnt;
    rdata = '0;
    @(posedge clk);
    #1;
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    wait_cnt = 0;
    while (!bus_rsp.ack && wait_cnt < 20)
    begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (!bus_rsp.ack)
    begin
      errors++;
      $display("bus request to register %0d was never acknowledged", addr);
    end
    rdata       = bus_rsp.rdata;
    bus_req.req = 1'b0;
    wait_cnt = 0;
    while (bus_rsp.ack && wait_cnt < 20)
    begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (bus_rsp.ack)
    begin
      errors++;
      $display("ack stayed high after req was dropped");
    end
  endtask

  function automatic dec_cfg_t mode_cfg(input nrz_mode_e nrz, input demux_mode_e dmx,
                                        input derand_mode_e der, input logic swap,
                                        input logic bip, input logic inv);
    dec_cfg_t m;
    m          = '0;
    m.nrz_mode = nrz;
    m.demux    = dmx;
    m.derand   = der;
    m.swap     = swap;
    m.biphase  = bip;
    m.data_inv = inv;
    return m;
  endfunction

  // enables are stopped whenever this runs
  task automatic set_mode(input dec_cfg_t cfg);
    logic [15:0] dummy;
    repeat (4) @(posedge clk);
    bus_cycle(1'b1, REG_CONFIG, cfg, dummy);
    cur_cfg  = cfg;
    skip     = 32;
    bip_half = 1'b0;
    // scrambler taps of each polynomial
    case (cfg.derand)
      RNRZ9:   tap_a = 9;
      RNRZ11:  tap_a = 11;
      RNRZ15:  tap_a = 15;
      RNRZ17:  tap_a = 17;
      RNRZ23:  tap_a = 23;
      default: tap_a = 0;
    endcase
    case (cfg.derand)
      RNRZ9:   tap_b = 5;
      RNRZ11:  tap_b = 9;
      RNRZ15:  tap_b = 14;
      RNRZ17:  tap_b = 14;
      RNRZ23:  tap_b = 18;
      default: tap_b = 0;
    endcase
  endtask

  task automatic run_symbols(input int n);
    int target;
    target = sym_idx + n;
    @(negedge clk);
    run_en = 1'b1;
    while (sym_idx < target)
      @(negedge clk);
    run_en = 1'b0;
  endtask

  task automatic run_mode(input dec_cfg_t cfg, input int n);
    set_mode(cfg);
    run_symbols(n);
  endtask

  task automatic finish_test(input string name);
    if (checks == test_chk)
    begin
      errors++;
      $display("%s: no decoded bits were checked", name);
    end
    $display("%s done: %0d checks, %0d errors", name, checks - test_chk, errors - test_err);
    test_chk = checks;
    test_err = errors;
  endtask

  //----------------------------------------
  // test sequence
  //----------------------------------------
  initial
  begin
    void'($urandom(32'hccba_6433));
    rs        = 1'b1;
    run_en    = 1'b0;
    symb_en   = 1'b0;
    symb2x_en = 1'b0;
    sym       = '0;
    bus_req   = '0;
    cur_cfg   = '0;
    tap_a     = 0;
    tap_b     = 0;
    sym_idx   = 0;
    skip      = 0;
    errors    = 0;
    checks    = 0;
    test_err  = 0;
    test_chk  = 0;
    repeat (8) @(posedge clk);
    #1;
    rs = 1'b0;

    // register readback, then bit count over a fixed run
    for (int k = 0; k < 8; k++)
    begin
      c = 16'($urandom);
      bus_cycle(1'b1, REG_CONFIG, c, rd);
      bus_cycle(1'b0, REG_CONFIG, 16'h0, rd);
      checks++;
      if (rd != c)
      begin
        errors++;
        $display("Mismatch at %0t ns: config read %h, written %h", $time, rd, c);
      end
    end
    set_mode(mode_cfg(NRZ_L, DEMUX_NONE, DERAND_OFF, 1'b0, 1'b0, 1'b0));
    bus_cycle(1'b1, REG_BITCOUNT, 16'h0, rd);
    run_symbols(COUNT_SYMS);
    repeat (4) @(posedge clk);
    bus_cycle(1'b0, REG_BITCOUNT, 16'h0, rd);
    checks++;
    // one strobe per symbol in NRZ-L
    if (rd != 16'(COUNT_SYMS))
    begin
      errors++;
      $display("Mismatch at %0t ns: bit count %0d, expected %0d", $time, rd, COUNT_SYMS);
    end
    bus_cycle(1'b1, REG_BITCOUNT, 16'h0, rd);
    bus_cycle(1'b0, REG_BITCOUNT, 16'h0, rd);
    checks++;
    if (rd != 16'h0)
    begin
      errors++;
      $display("Mismatch at %0t ns: bit count %0d after clear", $time, rd);
    end
    finish_test("register access");

    run_mode(mode_cfg(NRZ_L, DEMUX_NONE, DERAND_OFF, 1'b0, 1'b0, 1'b0), RUN_SYMS);
    run_mode(mode_cfg(NRZ_M, DEMUX_NONE, DERAND_OFF, 1'b0, 1'b0, 1'b0), RUN_SYMS);
    run_mode(mode_cfg(NRZ_S, DEMUX_NONE, DERAND_OFF, 1'b0, 1'b0, 1'b0), RUN_SYMS);
    run_mode(mode_cfg(NRZ_L, DEMUX_NONE, DERAND_OFF, 1'b1, 1'b0, 1'b1), RUN_SYMS);
    run_mode(mode_cfg(NRZ_M, DEMUX_NONE, DERAND_OFF, 1'b1, 1'b0, 1'b0), RUN_SYMS);
    run_mode(mode_cfg(NRZ_S, DEMUX_NONE, DERAND_OFF, 1'b0, 1'b0, 1'b1), RUN_SYMS);
    finish_test("nrz decoding");

    run_mode(mode_cfg(NRZ_L, DEMUX_NONE, DERAND_OFF, 1'b0, 1'b1, 1'b0), 2 * RUN_SYMS);
    finish_test("biphase input");

    run_mode(mode_cfg(NRZ_L, DEMUX_QPSK, DERAND_OFF, 1'b0, 1'b0, 1'b0), RUN_SYMS);
    run_mode(mode_cfg(NRZ_M, DEMUX_QPSK, DERAND_OFF, 1'b1, 1'b0, 1'b1), RUN_SYMS);
    run_mode(mode_cfg(NRZ_L, DEMUX_FQPSK, DERAND_OFF, 1'b0, 1'b0, 1'b0), RUN_SYMS);
    run_mode(mode_cfg(NRZ_L, DEMUX_FQPSK, DERAND_OFF, 1'b1, 1'b0, 1'b0), RUN_SYMS);
    finish_test("qpsk and fqpsk demux");

    for (int k = 1; k <= 5; k++)
      run_mode(mode_cfg(NRZ_L, DEMUX_NONE, derand_mode_e'(3'(k)), 1'b0, 1'b0, 1'b0),
               DERAND_SYMS);
    finish_test("derandomizer");

    asrt = dut_i.ctrl_i.ctrl_chk_i.fails + dut_i.derand_i.derand_chk_i.fails;
    $display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors, asrt);
    if (errors == 0 && asrt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // run length guard
  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/decoder_checker.sv
//----------------------------------------
// bound assertions on bus handshake,
// bit strobe and reset state
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decoder_checker (
  input logic clk,
  input logic rs,
  input logic req_i,
  input logic ack_i,
  input logic strobe_i,
  input logic sclk_i
);

  // failure count, read by the testbench at the end
  int unsigned fails = 0;

  // ack answers a req seen on the previous edge
  ack_rise_a: assert property (@(posedge clk) disable iff (rs) $rose(ack_i) |-> $past(req_i))
    else
    begin
      fails++;
      $error("ack rose without a pending req");
    end

  // ack drops only once req is low
  ack_fall_a: assert property (@(posedge clk) disable iff (rs) $fell(ack_i) |-> !$past(req_i))
    else
    begin
      fails++;
      $error("ack fell while req was still high");
    end

  // strobe is a single-cycle pulse
  strobe_a: assert property (@(posedge clk) disable iff (rs) strobe_i |=> !strobe_i)
    else
    begin
      fails++;
      $error("bit strobe high on two consecutive cycles");
    end

  // outputs quiet while reset is held
  reset_a: assert property (@(posedge clk) rs |-> (!ack_i && !strobe_i && !sclk_i))
    else
    begin
      fails++;
      $error("output active during reset");
    end

endmodule

//----------------------------------------
// handshake and count strobe in the register block
bind decoder_ctrl decoder_checker ctrl_chk_i (
  .clk      (clk),
  .rs       (rs),
  .req_i    (bus_req_i.req),
  .ack_i    (bus_rsp_o.ack),
  .strobe_i (bit_strobe_i),
  .sclk_i   (1'b0)
);

// output strobe and symbol clock
bind derandomizer decoder_checker derand_chk_i (
  .clk      (clk),
  .rs       (rs),
  .req_i    (1'b0),
  .ack_i    (1'b0),
  .strobe_i (bits_o.strobe),
  .sclk_i   (symb_clk_o)
);

`default_nettype wire

//--- verilog/decoder.sv
//----------------------------------------
// decoder top, register block and
// datapath stage chain
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  logic                   clk,
  input  logic                   rs,
  input  dec_cfg_pkg::bus_req_t  bus_req_i,
  output dec_cfg_pkg::bus_rsp_t  bus_rsp_o,
  input  logic                   symb_en_i,
  input  logic                   symb2x_en_i,
  input  dec_sym_pkg::sym_t      sym_i,
  output dec_sym_pkg::dec_bits_t bits_o,
  output logic                   symb_clk_o
);

  import dec_cfg_pkg::*;
  import dec_sym_pkg::*;

  // configuration fanned out to every stage
  dec_cfg_t cfg;
  // stage outputs along the chain
  sym_t     nrz;
  sym_t     dec;
  sym_t     sel;

  //----------------------------------------
  // register block
  //----------------------------------------
  // bit count follows the output strobe
  decoder_ctrl ctrl_i (
    .clk          (clk),
    .rs           (rs),
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .bit_strobe_i (bits_o.strobe),
    .cfg_o        (cfg)
  );

  //----------------------------------------
  // datapath
  //----------------------------------------
  biphase_to_nrz biphase_i (
    .clk       (clk),
    .rs        (rs),
    .symb_en_i (symb_en_i),
    .cfg_i     (cfg),
    .sym_i     (sym_i),
    .nrz_o     (nrz)
  );

  mark_space_decode msd_i (
    .clk       (clk),
    .rs        (rs),
    .symb_en_i (symb_en_i),
    .cfg_i     (cfg),
    .nrz_i     (nrz),
    .dec_o     (dec)
  );

  // runs on the half-symbol enable
  iq_demux demux_i (
    .clk         (clk),
    .rs          (rs),
    .symb_en_i   (symb_en_i),
    .symb2x_en_i (symb2x_en_i),
    .cfg_i       (cfg),
    .dec_i       (dec),
    .sel_o       (sel)
  );

  derandomizer derand_i (
    .clk         (clk),
    .rs          (rs),
    .symb_en_i   (symb_en_i),
    .symb2x_en_i (symb2x_en_i),
    .cfg_i       (cfg),
    .sel_i       (sel),
    .bits_o      (bits_o),
    .symb_clk_o  (symb_clk_o)
  );

endmodule

`default_nettype wire

//--- verilog/derandomizer.sv
//----------------------------------------
// randomized NRZ descrambler, inversion,
// bit strobe and symbol clock
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module derandomizer (
  input  logic                   clk,
  input  logic                   rs,
  input  logic                   symb_en_i,
  input  logic                   symb2x_en_i,
  input  dec_cfg_pkg::dec_cfg_t  cfg_i,
  input  dec_sym_pkg::sym_t      sel_i,
  output dec_sym_pkg::dec_bits_t bits_o,
  output logic                   symb_clk_o
);

  import dec_cfg_pkg::*;

  // received scrambled bits, shft[0] is the newest
  logic [22:0] shft;
  logic        demux_on;
  logic        shift_en;
  logic        strobe_en;
  logic        derand_on;
  logic        tap;
  logic        descr;
  logic        out_i;
  logic        out_q;
  logic        strobe;
  logic        symb_clk;

  assign demux_on = (cfg_i.demux == DEMUX_QPSK) || (cfg_i.demux == DEMUX_FQPSK);

  // biphase gives one bit per two symbols, marked by valid
  assign shift_en  = cfg_i.biphase ? (symb_en_i && sel_i.valid) :
                     (demux_on ? symb2x_en_i : symb_en_i);
  assign strobe_en = cfg_i.biphase ? shift_en :
                     ((demux_on && !cfg_i.clk_sel) ? symb2x_en_i : symb_en_i);

  // polynomial taps, stage n is shft[n-1]
  always_comb
  begin
    derand_on = 1'b1;
    case (cfg_i.derand)
      RNRZ9:   tap = shft[8] ^ shft[4];
      RNRZ11:  tap = shft[10] ^ shft[8];
      RNRZ15:  tap = shft[14] ^ shft[13];
      RNRZ17:  tap = shft[16] ^ shft[13];
      RNRZ23:  tap = shft[22] ^ shft[17];
      default:
      begin
        derand_on = 1'b0;
        tap       = 1'b0;
      end
    endcase
  end

  assign descr = sel_i.i ^ tap;

  //----------------------------------------
  // output bits, strobe and symbol clock
  //----------------------------------------
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      shft     <= '0;
      out_i    <= 1'b0;
      out_q    <= 1'b0;
      strobe   <= 1'b0;
      symb_clk <= 1'b0;
    end
    else
    begin
      // strobe lands with the bits it qualifies
      strobe <= strobe_en;
      if (shift_en)
      begin
        shft  <= {shft[21:0], sel_i.i};
        // descrambled bit goes on both rails
        out_i <= (derand_on ? descr : sel_i.i) ^ cfg_i.data_inv;
        out_q <= (derand_on ? descr : sel_i.q) ^ cfg_i.data_inv;
      end
      // high in the first half-symbol
      if (symb_en_i)
        symb_clk <= 1'b1;
      else if (symb2x_en_i)
        symb_clk <= !symb_clk;
    end
  end

  assign bits_o.bit_i  = out_i;
  assign bits_o.bit_q  = out_q;
  assign bits_o.strobe = strobe;
  assign symb_clk_o    = symb_clk;

endmodule

`default_nettype wire

//--- verilog/iq_demux.sv
//----------------------------------------
// I/Q swap, QPSK and FQPSK demux,
// output selection
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module iq_demux (
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  symb_en_i,
  input  logic                  symb2x_en_i,
  input  dec_cfg_pkg::dec_cfg_t cfg_i,
  input  dec_sym_pkg::sym_t     dec_i,
  output dec_sym_pkg::sym_t     sel_o
);

  import dec_cfg_pkg::*;

  // high at the mid-symbol event, low at symbol start
  logic half;
  // i rail one half-symbol back, for FQPSK
  logic dly_i;
  logic first;
  logic serial;
  logic fq_bit;
  logic sel_i;
  logic sel_q;
  logic sel_valid;

  //----------------------------------------
  // half-symbol phase
  //----------------------------------------
  // dec_i changes at symbol start, so the held symbol
  // is first seen at mid-symbol and last at the next start
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      half      <= 1'b0;
      sel_valid <= 1'b0;
    end
    else if (symb2x_en_i)
    begin
      half      <= symb_en_i;
      sel_valid <= dec_i.valid;
    end
  end

  // swap exchanges the serial order
  assign first  = half ^ cfg_i.swap;
  assign serial = first ? dec_i.i : dec_i.q;
  // inverted on alternate halves
  assign fq_bit = dly_i ^ dec_i.q ^ !first;

  //----------------------------------------
  // output selection
  //----------------------------------------
  always_ff @(posedge clk)
  begin
    if (symb2x_en_i)
    begin
      dly_i <= dec_i.i;
      case (cfg_i.demux)
        DEMUX_QPSK:
        begin
          sel_i <= serial;
          sel_q <= !serial;
        end
        DEMUX_FQPSK:
        begin
          sel_i <= fq_bit;
          sel_q <= !fq_bit;
        end
        default:
        begin
          sel_i <= cfg_i.swap ? dec_i.q : dec_i.i;
          sel_q <= cfg_i.swap ? dec_i.i : dec_i.q;
        end
      endcase
    end
  end

  assign sel_o.i     = sel_i;
  assign sel_o.q     = sel_q;
  assign sel_o.valid = sel_valid;

endmodule

`default_nettype wire

//--- verilog/mark_space_decode.sv
//----------------------------------------
// NRZ-L/M/S differential decode, I and Q
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mark_space_decode (
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  symb_en_i,
  input  dec_cfg_pkg::dec_cfg_t cfg_i,
  input  dec_sym_pkg::sym_t     nrz_i,
  output dec_sym_pkg::sym_t     dec_o
);

  import dec_cfg_pkg::*;

  logic prev_i;
  logic prev_q;
  logic dec_i;
  logic dec_q;
  logic dec_valid;

  // one rail, mark is a change and space is no change
  function automatic logic ms_bit(input nrz_mode_e mode, input logic cur, input logic prev);
    case (mode)
      NRZ_M:   ms_bit = cur ^ prev;
      NRZ_S:   ms_bit = !(cur ^ prev);
      default: ms_bit = cur;
    endcase
  endfunction

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
      dec_valid <= 1'b0;
    else if (symb_en_i)
      dec_valid <= nrz_i.valid;
  end

  // previous bit advances only on real bits
  always_ff @(posedge clk)
  begin
    if (symb_en_i && nrz_i.valid)
    begin
      prev_i <= nrz_i.i;
      prev_q <= nrz_i.q;
      dec_i  <= ms_bit(cfg_i.nrz_mode, nrz_i.i, prev_i);
      dec_q  <= ms_bit(cfg_i.nrz_mode, nrz_i.q, prev_q);
    end
  end

  assign dec_o.i     = dec_i;
  assign dec_o.q     = dec_q;
  assign dec_o.valid = dec_valid;

endmodule

`default_nettype wire

//--- verilog/biphase_to_nrz.sv
//----------------------------------------
// biphase half-symbol pairing and
// I/Q realignment
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module biphase_to_nrz (
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  symb_en_i,
  input  dec_cfg_pkg::dec_cfg_t cfg_i,
  input  dec_sym_pkg::sym_t     sym_i,
  output dec_sym_pkg::sym_t     nrz_o
);

  // previous half-symbol of each rail
  logic half_i;
  logic half_q;
  // high when the next sample should be a second half
  logic phase;
  logic emit;
  logic nrz_i;
  logic nrz_q;
  logic nrz_valid;

  // mid-bit transition closes the bit
  // no transition where one is expected means a bit boundary
  assign emit = phase && (half_i != sym_i.i);

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      phase     <= 1'b0;
      nrz_valid <= 1'b0;
    end
    else if (symb_en_i)
    begin
      if (cfg_i.biphase)
      begin
        // phase stays set until a pair closes
        phase     <= !emit;
        nrz_valid <= emit;
      end
      else
      begin
        phase     <= 1'b0;
        nrz_valid <= sym_i.valid;
      end
    end
  end

  // history and output bits
  always_ff @(posedge clk)
  begin
    if (symb_en_i)
    begin
      half_i <= sym_i.i;
      half_q <= sym_i.q;
      if (!cfg_i.biphase)
      begin
        nrz_i <= sym_i.i;
        nrz_q <= sym_i.q;
      end
      else if (emit)
      begin
        // first half carries the bit, high/low gives 1
        // q follows the i alignment
        nrz_i <= half_i;
        nrz_q <= half_q;
      end
    end
  end

  assign nrz_o.i     = nrz_i;
  assign nrz_o.q     = nrz_q;
  assign nrz_o.valid = nrz_valid;

endmodule

`default_nettype wire

//--- verilog/decoder_ctrl.sv
//----------------------------------------
// register bus slave, config register
// and decoded-bit counter
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decoder_ctrl (
  input  logic                  clk,
  input  logic                  rs,
  input  dec_cfg_pkg::bus_req_t bus_req_i,
  output dec_cfg_pkg::bus_rsp_t bus_rsp_o,
  input  logic                  bit_strobe_i,
  output dec_cfg_pkg::dec_cfg_t cfg_o
);

  import dec_cfg_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_REQ_LOW
  } hs_state_e;

  hs_state_e   state;
  dec_cfg_t    cfg_q;
  logic [15:0] bit_cnt;
  logic [15:0] rdata_q;
  logic        access;
  logic        wr_cfg;
  logic        wr_cnt;

  // access only from idle, so once per req rise
  assign access = (state == IDLE) && bus_req_i.req;
  assign wr_cfg = access && bus_req_i.we && (bus_req_i.addr == REG_CONFIG);
  assign wr_cnt = access && bus_req_i.we && (bus_req_i.addr == REG_BITCOUNT);

  //----------------------------------------
  // handshake fsm
  //----------------------------------------
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
      state <= IDLE;
    else
    begin
      case (state)
        IDLE:
          if (bus_req_i.req)
            state <= ACK;
        // req may already be low in the first ack cycle
        ACK:
          state <= bus_req_i.req ? WAIT_REQ_LOW : IDLE;
        WAIT_REQ_LOW:
          if (!bus_req_i.req)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // config register, saturating bit count
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      cfg_q   <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      if (wr_cfg)
        cfg_q <= dec_cfg_t'(bus_req_i.wdata);
      if (wr_cnt)
        bit_cnt <= '0;
      else if (bit_strobe_i && (bit_cnt != 16'hffff))
        bit_cnt <= bit_cnt + 16'd1;
    end
  end

  // read data held through the ack phase
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      case (bus_req_i.addr)
        REG_CONFIG:   rdata_q <= cfg_q;
        REG_BITCOUNT: rdata_q <= bit_cnt;
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign bus_rsp_o.ack   = (state != IDLE);
  assign bus_rsp_o.rdata = rdata_q;
  assign cfg_o           = cfg_q;

endmodule

`default_nettype wire

//--- verilog/dec_sym_pkg.sv
//----------------------------------------
// symbol and decoded-bit structs
//----------------------------------------
`default_nettype none

package dec_sym_pkg;

  // hard decisions passed between stages
  // valid marks a new bit in biphase mode
  typedef struct packed {
    logic i;
    logic q;
    logic valid;
  } sym_t;

  // decoder output, bits sampled with strobe
  typedef struct packed {
    logic bit_i;
    logic bit_q;
    logic strobe;
  } dec_bits_t;

endpackage

`default_nettype wire

//--- verilog/dec_cfg_pkg.sv
//----------------------------------------
// register map, configuration struct,
// decoder mode enums and register bus structs
//----------------------------------------
`default_nettype none

package dec_cfg_pkg;

  //----------------------------------------
  // register map
  //----------------------------------------
  typedef logic [3:0] addr_t;

  localparam addr_t REG_CONFIG   = 4'd0;
  localparam addr_t REG_BITCOUNT = 4'd1;

  //----------------------------------------
  // mode encodings
  //----------------------------------------
  // differential decode of each rail
  typedef enum logic [1:0] {
    NRZ_L = 2'd0,
    NRZ_M = 2'd1,
    NRZ_S = 2'd2
  } nrz_mode_e;

  // randomized NRZ polynomial, zero means bypass
  typedef enum logic [2:0] {
    DERAND_OFF = 3'd0,
    RNRZ9      = 3'd1,
    RNRZ11     = 3'd2,
    RNRZ15     = 3'd3,
    RNRZ17     = 3'd4,
    RNRZ23     = 3'd5
  } derand_mode_e;

  typedef enum logic [1:0] {
    DEMUX_NONE  = 2'd0,
    DEMUX_QPSK  = 2'd1,
    DEMUX_FQPSK = 2'd2
  } demux_mode_e;

  // REG_CONFIG bit layout, msb first
  typedef struct packed {
    logic [4:0]   spare;
    derand_mode_e derand;
    nrz_mode_e    nrz_mode;
    demux_mode_e  demux;
    logic         swap;
    logic         biphase;
    logic         data_inv;
    // symbol rate strobe in demux modes
    logic         clk_sel;
  } dec_cfg_t;

  //----------------------------------------
  // four-phase register bus
  //----------------------------------------
  typedef struct packed {
    logic        req;
    logic        we;
    addr_t       addr;
    logic [15:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire
